//--- common/video_pkg.sv
package video_pkg;

  // display raster coordinates
  typedef logic [10:0] hcount_t; // display column
  typedef logic [9:0]  vcount_t; // display line

  // camera image coordinates
  typedef logic [8:0] img_x_t; // image column
  typedef logic [7:0] img_y_t; // image row

  typedef logic [15:0] pixel565_t; // rgb565 camera pixel
  typedef logic [11:0] rgb444_t;   // 4 bits per colour toward the dac

  // one raster position, syncs active high inside the design
  typedef struct packed {
    hcount_t hcount;
    vcount_t vcount;
    logic    hsync;
    logic    vsync;
    logic    blank; // high outside the active area
  } raster_t;

  // recovered camera pixel, one write per valid cycle
  typedef struct packed {
    logic      valid;
    img_x_t    img_x;
    img_y_t    img_y;
    pixel565_t pixel;
  } pix_wr_t;

endpackage

//--- common/vision_pkg.sv
package vision_pkg;

  // colour channel used for thresholding
  typedef enum logic [1:0] {
    CH_RED   = 2'd0,
    CH_GREEN = 2'd1,
    CH_BLUE  = 2'd2
  } channel_e;

  // what goes out on the vga pins
  typedef enum logic [1:0] {
    MODE_CAMERA    = 2'd0, // rgb444 image
    MODE_MASK      = 2'd1, // black and white mask
    MODE_CROSSHAIR = 2'd2, // image with green cross on the centroid
    MODE_PINK      = 2'd3  // test screen
  } mode_e;

  typedef logic [3:0]  level_t; // top four bits of a channel, also the bounds
  typedef logic [31:0] sum_t;   // accumulators and divider operands

  // centroid in display coordinates
  typedef struct packed {
    video_pkg::hcount_t x;
    video_pkg::vcount_t y;
  } com_t;

endpackage

//--- filelist.f
common/video_pkg.sv
common/vision_pkg.sv
rtl/vga_timing.sv
frame_store/frame_store.sv
tracking/mask_threshold.sv
tracking/center_of_mass.sv
rtl/display_compose.sv
rtl/tracker_top.sv
testbench/tracker_checker.sv
testbench/tracker_tb.sv

//--- frame_store/frame_store.sv
`timescale 1ns/1ps

module frame_store #(
  parameter int IMG_W = 320,
  parameter int IMG_H = 240
) (
  input  logic                 clk_65mhz,
  input  logic                 sys_rst,
  input  video_pkg::pix_wr_t   pix_wr,
  input  video_pkg::raster_t   raster,
  output video_pkg::pixel565_t pixel
);
  import video_pkg::*;

  localparam int DEPTH  = IMG_W * IMG_H;
  localparam int ADDR_W = $clog2(DEPTH);

  typedef logic [ADDR_W-1:0] addr_t;

  pixel565_t mem [0:DEPTH-1]; // whole camera frame

  // write side
  logic  wr_en;
  addr_t wr_addr;

  // read side
  img_x_t    rd_x;
  img_y_t    rd_y;
  logic      in_img;  // raster falls on the scaled image
  addr_t     rd_addr;
  pixel565_t mem_q1;
  pixel565_t mem_q2;
  logic      in_q1;
  logic      in_q2;

  // drop anything outside the image so the index stays in range
  assign wr_en = pix_wr.valid &&
                 (pix_wr.img_x < img_x_t'(IMG_W)) &&
                 (pix_wr.img_y < img_y_t'(IMG_H));
  assign wr_addr = addr_t'(pix_wr.img_y * IMG_W + pix_wr.img_x); // row major

  // 2x upscale: two display columns and two lines per image pixel
  assign in_img = (raster.hcount < hcount_t'(2 * IMG_W)) &&
                  (raster.vcount < vcount_t'(2 * IMG_H));

  // horizontal mirror, column counts down from the right edge
  assign rd_x = img_x_t'(IMG_W - 1) - img_x_t'(raster.hcount >> 1);
  assign rd_y = img_y_t'(raster.vcount >> 1);

  // park the address at 0 outside the image, result is masked anyway
  assign rd_addr = in_img ? addr_t'(rd_y * IMG_W + rd_x) : '0;

  // one block for both ports: the read sees the old word on a collision
  always_ff @(posedge clk_65mhz) begin
    if (wr_en)
      mem[wr_addr] <= pix_wr.pixel; // visible one cycle after valid
    mem_q1 <= mem[rd_addr];         // first read stage
    mem_q2 <= mem_q1;               // second read stage
  end

  // in-image flag follows the data through both stages
  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      in_q1 <= 1'b0;
      in_q2 <= 1'b0;
    end else begin
      in_q1 <= in_img;
      in_q2 <= in_q1;
    end
  end

  // black outside the image area
  assign pixel = in_q2 ? mem_q2 : '0;

endmodule

//--- rtl/display_compose.sv
`timescale 1ns/1ps

module display_compose (
  input  logic                 clk_65mhz,
  input  logic                 sys_rst,
  input  video_pkg::raster_t   raster,
  input  video_pkg::pixel565_t pixel,
  input  logic                 mask,
  input  vision_pkg::com_t     com,
  input  logic                 com_valid,
  input  vision_pkg::mode_e    mode,
  output logic [3:0]           vga_r,
  output logic [3:0]           vga_g,
  output logic [3:0]           vga_b,
  output logic                 vga_hs,
  output logic                 vga_vs
);
  import video_pkg::*;
  import vision_pkg::*;

  com_t    com_hold;  // last finished centroid
  rgb444_t cam_rgb;
  rgb444_t mix_rgb;
  logic    crosshair;

  // centroid only changes when a new one is done
  always_ff @(posedge clk_65mhz) begin
    if (sys_rst)
      com_hold <= '0;
    else if (com_valid)
      com_hold <= com;
  end

  assign cam_rgb   = {pixel[15:12], pixel[10:7], pixel[4:1]}; // 565 down to 444
  assign crosshair = (raster.hcount == com_hold.x) || (raster.vcount == com_hold.y);

  // mode mux
  always_comb begin
    case (mode)
      MODE_CAMERA:    mix_rgb = cam_rgb;
      MODE_MASK:      mix_rgb = mask ? 12'hFFF : 12'h000;
      MODE_CROSSHAIR: mix_rgb = crosshair ? 12'h0F0 : cam_rgb;
      MODE_PINK:      mix_rgb = 12'hF0F;
      default:        mix_rgb = cam_rgb;
    endcase
  end

  // output stage, syncs go active low on the pins
  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      vga_r  <= '0;
      vga_g  <= '0;
      vga_b  <= '0;
      vga_hs <= 1'b1;
      vga_vs <= 1'b1;
    end else begin
      vga_r  <= raster.blank ? 4'h0 : mix_rgb[11:8]; // nothing during blanking
      vga_g  <= raster.blank ? 4'h0 : mix_rgb[7:4];
      vga_b  <= raster.blank ? 4'h0 : mix_rgb[3:0];
      vga_hs <= ~raster.hsync;
      vga_vs <= ~raster.vsync;
    end
  end

endmodule

//--- rtl/tracker_top.sv
`timescale 1ns/1ps

module tracker_top #(
  parameter int H_ACTIVE = 1024,
  parameter int H_FP     = 24,
  parameter int H_SYNC   = 136,
  parameter int H_BP     = 160,
  parameter int V_ACTIVE = 768,
  parameter int V_FP     = 3,
  parameter int V_SYNC   = 6,
  parameter int V_BP     = 29,
  parameter int IMG_W    = 320,
  parameter int IMG_H    = 240
) (
  input  logic                 clk_65mhz,
  input  logic                 sys_rst,
  input  video_pkg::pix_wr_t   pix_wr,   // camera pixel stream
  input  vision_pkg::channel_e channel,
  input  vision_pkg::level_t   lower,
  input  vision_pkg::level_t   upper,
  input  vision_pkg::mode_e    mode,
  output logic [3:0]           vga_r,
  output logic [3:0]           vga_g,
  output logic [3:0]           vga_b,
  output logic                 vga_hs,   // active low
  output logic                 vga_vs,   // active low
  output vision_pkg::com_t     com,
  output logic                 com_valid
);
  import video_pkg::*;

  localparam int FRAME_LAT = 2; // frame store read latency

  raster_t   raster0;              // straight from the timing generator
  raster_t   raster_d [FRAME_LAT]; // raster_d[FRAME_LAT-1] lines up with pixel
  pixel565_t pixel;
  logic      mask;

  vga_timing #(
    .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
    .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
  ) timing0 (
    .clk_65mhz(clk_65mhz),
    .sys_rst  (sys_rst),
    .raster   (raster0)
  );

  frame_store #(
    .IMG_W(IMG_W),
    .IMG_H(IMG_H)
  ) store0 (
    .clk_65mhz(clk_65mhz),
    .sys_rst  (sys_rst),
    .pix_wr   (pix_wr),
    .raster   (raster0),
    .pixel    (pixel)
  );

  // raster follows the pixel through the memory stages
  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      for (int i = 0; i < FRAME_LAT; i++)
        raster_d[i] <= '{hcount: '0, vcount: '0, hsync: 1'b0, vsync: 1'b0, blank: 1'b1};
    end else begin
      raster_d[0] <= raster0;
      for (int i = 1; i < FRAME_LAT; i++)
        raster_d[i] <= raster_d[i-1];
    end
  end

  mask_threshold thresh0 (
    .pixel  (pixel),
    .channel(channel),
    .lower  (lower),
    .upper  (upper),
    .mask   (mask)
  );

  center_of_mass com0 (
    .clk_65mhz(clk_65mhz),
    .sys_rst  (sys_rst),
    .raster   (raster_d[FRAME_LAT-1]),
    .mask     (mask),
    .com      (com),
    .com_valid(com_valid)
  );

  // one more register here brings the total to three cycles
  display_compose compose0 (
    .clk_65mhz(clk_65mhz),
    .sys_rst  (sys_rst),
    .raster   (raster_d[FRAME_LAT-1]),
    .pixel    (pixel),
    .mask     (mask),
    .com      (com),
    .com_valid(com_valid),
    .mode     (mode),
    .vga_r    (vga_r),
    .vga_g    (vga_g),
    .vga_b    (vga_b),
    .vga_hs   (vga_hs),
    .vga_vs   (vga_vs)
  );

endmodule

//--- rtl/vga_timing.sv
`timescale 1ns/1ps

module vga_timing #(
  parameter int H_ACTIVE = 1024,
  parameter int H_FP     = 24,
  parameter int H_SYNC   = 136,
  parameter int H_BP     = 160,
  parameter int V_ACTIVE = 768,
  parameter int V_FP     = 3,
  parameter int V_SYNC   = 6,
  parameter int V_BP     = 29
) (
  input  logic               clk_65mhz,
  input  logic               sys_rst,
  output video_pkg::raster_t raster
);
  import video_pkg::*;

  localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
  localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;
  localparam int HS_START = H_ACTIVE + H_FP; // first sync column
  localparam int VS_START = V_ACTIVE + V_FP; // first sync line

  hcount_t h_cnt;
  vcount_t v_cnt;

  // free running raster counters
  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_cnt == hcount_t'(H_TOTAL - 1)) begin
      h_cnt <= '0; // end of line
      if (v_cnt == vcount_t'(V_TOTAL - 1))
        v_cnt <= '0; // end of frame
      else
        v_cnt <= v_cnt + 1'b1;
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  // stage 0 raster, decoded straight off the counters
  assign raster.hcount = h_cnt;
  assign raster.vcount = v_cnt;
  assign raster.hsync  = (h_cnt >= hcount_t'(HS_START)) &&
                         (h_cnt <  hcount_t'(HS_START + H_SYNC));
  assign raster.vsync  = (v_cnt >= vcount_t'(VS_START)) &&
                         (v_cnt <  vcount_t'(VS_START + V_SYNC));
  assign raster.blank  = (h_cnt >= hcount_t'(H_ACTIVE)) ||
                         (v_cnt >= vcount_t'(V_ACTIVE));

endmodule

//--- testbench/tracker_checker.sv
`timescale 1ns/1ps

module tracker_checker (
  input logic       clk_65mhz,
  input logic       sys_rst,
  input logic [3:0] vga_r,
  input logic [3:0] vga_g,
  input logic [3:0] vga_b,
  input logic       vga_hs,
  input logic       vga_vs,
  input logic       com_valid
);

  int assert_fails = 0; // picked up by the testbench at the end

  // no colour while either sync pulse is on
  sync_dark: assert property (@(posedge clk_65mhz) disable iff (sys_rst)
    (!vga_hs || !vga_vs) |-> ({vga_r, vga_g, vga_b} == 12'h000))
    else begin
      assert_fails++;
      $error("colour outputs active during a sync pulse");
    end

  // centroid strobe is a single cycle
  pulse_short: assert property (@(posedge clk_65mhz) disable iff (sys_rst)
    com_valid |=> !com_valid)
    else begin
      assert_fails++;
      $error("com_valid high for more than one cycle");
    end

  // reset leaves every output idle
  reset_idle: assert property (@(posedge clk_65mhz)
    sys_rst |=> (vga_hs && vga_vs && !com_valid && ({vga_r, vga_g, vga_b} == 12'h000)))
    else begin
      assert_fails++;
      $error("outputs not idle after a reset cycle");
    end

endmodule

bind tracker_top tracker_checker checker0 (
  .clk_65mhz(clk_65mhz),
  .sys_rst  (sys_rst),
  .vga_r    (vga_r),
  .vga_g    (vga_g),
  .vga_b    (vga_b),
  .vga_hs   (vga_hs),
  .vga_vs   (vga_vs),
  .com_valid(com_valid)
);

//--- testbench/tracker_patterns.mem
// channel lower upper mode | x0 y0 x1 y1 | fg bg (rgb565) | centroid x y
// channel 0 red 1 green 2 blue, mode 0 camera 1 mask 2 crosshair 3 pink, FFFF FFFF no pulse
0 8 F 0  2 3 5 6  F800 001F  0017 0009
1 4 9 1  0 0 3 1  0300 FFFF  001B 0001
2 A F 2  A 8 F B  001F F800  0005 0013
0 8 F 0  0 0 F B  07E0 001F  FFFF FFFF
0 1 3 3  0 0 F B  2000 0000  000F 000B
2 0 3 1  4 2 7 5  0004 001F  0019 0012
1 C F 2  7 5 7 5  07E0 0000  0010 000A

//--- testbench/tracker_tb.sv
`timescale 1ns/1ps

module tracker_tb;
  import video_pkg::*;
  import vision_pkg::*;

  localparam int H_ACTIVE = 40;
  localparam int H_FP = 2;
  localparam int H_SYNC = 4;
  localparam int H_BP = 4;
  localparam int V_ACTIVE = 30;
  localparam int V_FP = 1;
  localparam int V_SYNC = 2;
  localparam int V_BP = 2;
  localparam int IMG_W = 16;
  localparam int IMG_H = 12;
  localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP; // 50 columns
  localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP; // 35 lines
  localparam int HS_START = H_ACTIVE + H_FP;
  localparam int VS_START = V_ACTIVE + V_FP;
  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
  localparam int NUM_CASES = 7;
  localparam int FIELDS = 12; // words per pattern line

  logic       clk_65mhz = 1'b0;
  logic       sys_rst;
  pix_wr_t    pix_wr;
  channel_e   channel;
  level_t     lower;
  level_t     upper;
  mode_e      mode;
  logic [3:0] vga_r;
  logic [3:0] vga_g;
  logic [3:0] vga_b;
  logic       vga_hs;
  logic       vga_vs;
  com_t       com;
  logic       com_valid;

  logic [15:0] pat [0:NUM_CASES*FIELDS-1]; // pattern file words
  pixel565_t   img [0:IMG_W*IMG_H-1];      // image as the dut should hold it
  int   err_value = 0;
  int   err_other = 0;
  int   timeouts = 0;
  logic timed_out = 1'b0;
  // raster tracking from the output syncs
  int        col = 0;
  int        line = 0;
  int        hs_low = 0;
  int        vs_low = 0;
  int        pulse_cnt = 0;
  logic      h_lock;
  logic      v_lock;
  logic      hs_prev;
  logic      vs_prev;
  logic      check_en;
  com_t      exp_hold;  // centroid the crosshair should sit on
  pixel565_t src;
  rgb444_t   want;

  always #50 clk_65mhz = ~clk_65mhz;

  tracker_top #(
    .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
    .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP),
    .IMG_W(IMG_W), .IMG_H(IMG_H)
  ) dut0 (
    .clk_65mhz(clk_65mhz), .sys_rst(sys_rst), .pix_wr(pix_wr), .channel(channel),
    .lower(lower), .upper(upper), .mode(mode), .vga_r(vga_r), .vga_g(vga_g),
    .vga_b(vga_b), .vga_hs(vga_hs), .vga_vs(vga_vs), .com(com), .com_valid(com_valid)
  );

  // mirror and 2x scale, black outside the image
  function automatic pixel565_t shown_pixel(input int c, input int l);
    if (c < 2 * IMG_W && l < 2 * IMG_H)
      return img[(l / 2) * IMG_W + (IMG_W - 1 - c / 2)];
    return '0;
  endfunction

  function automatic rgb444_t to_rgb444(input pixel565_t p);
    return {p[15:12], p[10:7], p[4:1]}; // top four bits per channel
  endfunction

  function automatic logic in_window(input pixel565_t p);
    level_t v;
    case (channel)
      CH_RED:   v = p[15:12];
      CH_GREEN: v = p[10:7];
      default:  v = p[4:1];
    endcase
    return (v >= lower) && (v <= upper);
  endfunction

  // idle outputs: dark colours, syncs high, no strobe
  task automatic check_idle(input string phase);
    if ({vga_r, vga_g, vga_b} !== 12'h000) begin
      $display("Error: {vga_r,vga_g,vga_b} %s is %h, expected 000", phase,
               {vga_r, vga_g, vga_b});
      err_value++;
    end
    if (vga_hs !== 1'b1) begin
      $display("Error: vga_hs %s is %h, expected 1", phase, vga_hs);
      err_value++;
    end
    if (vga_vs !== 1'b1) begin
      $display("Error: vga_vs %s is %h, expected 1", phase, vga_vs);
      err_value++;
    end
    if (com_valid !== 1'b0) begin
      $display("Error: com_valid %s is %h, expected 0", phase, com_valid);
      err_value++;
    end
  endtask

  // floor mean of the masked display coordinates over one frame
  task automatic predict_centroid(output com_t cen, output logic empty);
    longint sx;
    longint sy;
    longint n;
    sx = 0;
    sy = 0;
    n = 0;
    for (int l = 0; l < V_ACTIVE; l++) begin
      for (int c = 0; c < H_ACTIVE; c++) begin
        if (in_window(shown_pixel(c, l))) begin
          sx += c;
          sy += l;
          n++;
        end
      end
    end
    empty = (n == 0);
    cen = '0;
    if (!empty) begin
      cen.x = hcount_t'(sx / n);
      cen.y = vcount_t'(sy / n);
    end
  endtask

  task automatic wait_vs_fall();
    int   n;
    logic last;
    logic found;
    n = 0;
    last = 1'b0; // a sync already low does not count
    found = 1'b0;
    while (!found && !timed_out && n < 2 * FRAME_CYCLES) begin
      @(negedge clk_65mhz);
      found = last && !vga_vs;
      last = vga_vs;
      n++;
    end
    if (!found && !timed_out) begin
      $display("Timeout: no vertical sync pulse within two frames");
      timeouts++;
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_centroid(input com_t expect_com);
    int   n;
    logic seen;
    n = 0;
    seen = 1'b0;
    while (!seen && !timed_out && n < 2 * FRAME_CYCLES) begin
      @(negedge clk_65mhz);
      seen = com_valid;
      n++;
    end
    if (!seen && !timed_out) begin
      $display("Timeout: com_valid did not pulse within two frames");
      timeouts++;
      timed_out = 1'b1;
    end else if (seen && com !== expect_com) begin
      $display("Error: com is %h, expected %h", com, expect_com);
      err_value++;
    end
  endtask

  task automatic watch_no_pulse(input int cycles);
    for (int n = 0; n < cycles; n++) begin
      @(negedge clk_65mhz);
      if (com_valid) begin
        $display("com_valid pulsed although the mask is empty");
        err_other++;
      end
    end
  endtask

  task automatic run_case(input int k);
    int        b;
    logic      in_rect;
    logic      exp_empty;
    logic      file_empty;
    pixel565_t pix;
    com_t      exp_c;
    com_t      file_c;
    b = k * FIELDS;
    channel = channel_e'(pat[b][1:0]);
    lower = level_t'(pat[b + 1]);
    upper = level_t'(pat[b + 2]);
    mode = mode_e'(pat[b + 3][1:0]);
    for (int y = 0; y < IMG_H; y++) begin // rectangle over the background
      for (int x = 0; x < IMG_W; x++) begin
        in_rect = (x >= pat[b + 4]) && (x <= pat[b + 6]) &&
                  (y >= pat[b + 5]) && (y <= pat[b + 7]);
        pix = in_rect ? pat[b + 8] : pat[b + 9];
        img[y * IMG_W + x] = pix;
        pix_wr = '{valid: 1'b1, img_x: img_x_t'(x), img_y: img_y_t'(y), pixel: pix};
        @(negedge clk_65mhz);
      end
    end
    pix_wr.valid = 1'b0;
    predict_centroid(exp_c, exp_empty);
    file_empty = (pat[b + 10] == 16'hFFFF);
    file_c = '{x: hcount_t'(pat[b + 10]), y: vcount_t'(pat[b + 11])};
    if (file_empty != exp_empty || (!exp_empty && file_c != exp_c)) begin
      $display("Pattern line %0d gives a centroid that does not follow from its image", k);
      err_other++;
    end
    wait_vs_fall();
    wait_vs_fall(); // the frame from here on shows only the new image
    if (file_empty) begin
      watch_no_pulse(2 * FRAME_CYCLES);
    end else begin
      wait_centroid(file_c);
      exp_hold = file_c;
    end
    wait_vs_fall();
    pulse_cnt = 0;
    check_en = 1'b1; // pixel checks over one whole frame
    wait_vs_fall();
    check_en = 1'b0;
    if (!timed_out && pulse_cnt != (file_empty ? 0 : 1)) begin
      $display("com_valid pulsed %0d times in one frame in case %0d", pulse_cnt, k);
      err_other++;
    end
    if (!timed_out && file_empty && com !== exp_hold) begin
      $display("Error: com after an empty mask is %h, expected %h", com, exp_hold);
      err_value++;
    end
  endtask

  // raster tracking and per pixel checks, sampled mid cycle
  always @(negedge clk_65mhz) begin
    if (sys_rst) begin
      h_lock = 1'b0;
      v_lock = 1'b0;
      hs_prev = 1'b1;
      vs_prev = 1'b1;
      hs_low = 0;
      vs_low = 0;
      check_idle("in reset");
    end else begin
      col = (col + 1) % H_TOTAL;
      if (col == 0)
        line = (line + 1) % V_TOTAL;
      if (hs_prev && !vga_hs) begin // hsync opens on the first sync column
        if (h_lock && col != HS_START) begin
          $display("Horizontal sync started at column %0d instead of %0d", col, HS_START);
          err_other++;
        end
        col = HS_START;
        h_lock = 1'b1;
      end
      if (vs_prev && !vga_vs && h_lock) begin
        if (v_lock && line != VS_START) begin
          $display("Vertical sync started on line %0d instead of %0d", line, VS_START);
          err_other++;
        end
        line = VS_START;
        v_lock = 1'b1;
      end
      if (!vga_hs) begin
        hs_low++;
      end else begin
        if (!hs_prev && h_lock && hs_low != H_SYNC) begin
          $display("Horizontal sync was low for %0d columns instead of %0d", hs_low, H_SYNC);
          err_other++;
        end
        hs_low = 0;
      end
      if (!vga_vs) begin
        vs_low++;
      end else begin
        if (!vs_prev && v_lock && vs_low != V_SYNC * H_TOTAL) begin
          $display("Vertical sync was low for %0d cycles instead of %0d", vs_low,
                   V_SYNC * H_TOTAL);
          err_other++;
        end
        vs_low = 0;
      end
      hs_prev = vga_hs;
      vs_prev = vga_vs;
      if (com_valid)
        pulse_cnt++;
      if (v_lock && (col >= H_ACTIVE || line >= V_ACTIVE)) begin
        if ({vga_r, vga_g, vga_b} !== 12'h000) begin
          $display("Error: {vga_r,vga_g,vga_b} at blanked column %0d line %0d is %h, expected 000",
                   col, line, {vga_r, vga_g, vga_b});
          err_value++;
        end
      end else if (v_lock && check_en) begin
        src = shown_pixel(col, line);
        case (mode)
          MODE_CAMERA:    want = to_rgb444(src);
          MODE_MASK:      want = in_window(src) ? 12'hFFF : 12'h000;
          MODE_CROSSHAIR: want = (col == exp_hold.x || line == exp_hold.y) ?
                                 12'h0F0 : to_rgb444(src);
          default:        want = 12'hF0F;
        endcase
        if ({vga_r, vga_g, vga_b} !== want) begin
          $display("Error: {vga_r,vga_g,vga_b} at column %0d line %0d is %h, expected %h",
                   col, line, {vga_r, vga_g, vga_b}, want);
          err_value++;
        end
      end
    end
  end

  initial begin
    sys_rst = 1'b1;
    pix_wr = '0;
    channel = CH_RED;
    lower = '0;
    upper = '0;
    mode = MODE_CAMERA;
    check_en = 1'b0;
    exp_hold = '0; // com_hold clears in reset
    $readmemh("testbench/tracker_patterns.mem", pat);
    repeat (16) @(negedge clk_65mhz);
    sys_rst = 1'b0;
    @(negedge clk_65mhz);
    check_idle("after reset");
    for (int k = 0; k < NUM_CASES && !timed_out; k++)
      run_case(k);
    $display("Totals: %0d value errors, %0d other errors, %0d timeouts, %0d assertion failures",
             err_value, err_other, timeouts, dut0.checker0.assert_fails);
    if (err_value + err_other + timeouts + dut0.checker0.assert_fails == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

//--- tracking/center_of_mass.sv
`timescale 1ns/1ps

module center_of_mass (
  input  logic               clk_65mhz,
  input  logic               sys_rst,
  input  video_pkg::raster_t raster,
  input  logic               mask,
  output vision_pkg::com_t   com,
  output logic               com_valid
);
  import video_pkg::*;
  import vision_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_DIV,
    ST_DONE
  } div_state_e;

  div_state_e  state;
  sum_t        x_sum;
  sum_t        y_sum;
  sum_t        cnt;    // masked pixels this frame
  sum_t        div_d;  // divisor, the frame's pixel count
  sum_t        quo_x;  // dividend shifting out, quotient shifting in
  sum_t        quo_y;
  logic [32:0] rem_x;
  logic [32:0] rem_y;
  logic [4:0]  step;   // 32 iterations
  logic        frame_start;
  logic        hit;

  // one step of a restoring divider, returns {remainder, quotient}
  function automatic logic [64:0] div_step(input logic [32:0] rem,
                                           input sum_t quo,
                                           input sum_t d);
    logic [32:0] trial;
    trial = {rem[31:0], quo[31]}; // bring down the next dividend bit
    if (trial >= {1'b0, d}) begin
      return {trial - {1'b0, d}, quo[30:0], 1'b1};
    end else begin
      return {trial, quo[30:0], 1'b0};
    end
  endfunction

  assign frame_start = (raster.hcount == '0) && (raster.vcount == '0);
  assign hit         = !raster.blank && mask;

  // per frame sums, restarted at the top left pixel
  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      x_sum <= '0;
      y_sum <= '0;
      cnt   <= '0;
    end else if (frame_start) begin
      x_sum <= '0; // coordinates are zero here, only the count can move
      y_sum <= '0;
      cnt   <= hit ? sum_t'(1) : '0;
    end else if (hit) begin
      x_sum <= x_sum + sum_t'(raster.hcount);
      y_sum <= y_sum + sum_t'(raster.vcount);
      cnt   <= cnt + 1'b1;
    end
  end

  // two dividers in lock step sharing one divisor
  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      state     <= ST_IDLE;
      step      <= '0;
      com       <= '0;
      com_valid <= 1'b0;
    end else begin
      com_valid <= 1'b0; // single cycle pulse
      case (state)
        ST_IDLE: begin
          if (frame_start && (cnt != '0)) begin // empty mask keeps old com
            div_d <= cnt;
            quo_x <= x_sum;
            quo_y <= y_sum;
            rem_x <= '0;
            rem_y <= '0;
            step  <= '0;
            state <= ST_DIV;
          end
        end
        ST_DIV: begin
          {rem_x, quo_x} <= div_step(rem_x, quo_x, div_d);
          {rem_y, quo_y} <= div_step(rem_y, quo_y, div_d);
          step <= step + 1'b1;
          if (step == 5'd31)
            state <= ST_DONE;
        end
        ST_DONE: begin
          com.x     <= hcount_t'(quo_x); // floor of the mean, fits the raster
          com.y     <= vcount_t'(quo_y);
          com_valid <= 1'b1;
          state     <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

//--- tracking/mask_threshold.sv
`timescale 1ns/1ps

module mask_threshold (
  input  video_pkg::pixel565_t pixel,
  input  vision_pkg::channel_e channel,
  input  vision_pkg::level_t   lower,
  input  vision_pkg::level_t   upper,
  output logic                 mask
);
  import video_pkg::*;
  import vision_pkg::*;

  level_t value; // intensity of the selected channel

  // top four bits of each field of the rgb565 word
  always_comb begin
    case (channel)
      CH_RED:   value = pixel[15:12];
      CH_GREEN: value = pixel[10:7]; // green has six bits, drop two
      CH_BLUE:  value = pixel[4:1];
      default:  value = '0;
    endcase
  end

  // inclusive window
  assign mask = (value >= lower) && (value <= upper);

endmodule
